// ==== Makefile ====
TOP = cpuTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f build.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== build.f ====
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpu.sv
verification/cpu_assertions.sv
verification/cpuTb.sv

// ==== logic/cpu.sv ====
// Top level of the five-stage MIPS subset core, wiring the stages and exposing load, retire and store
module cpu (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::imemLoadT imemLoad,
	output cpuPkg::memWbT    retire,
	output cpuPkg::storeT    store
);

	cpuPkg::ifIdT     ifId;
	cpuPkg::idExT     idEx;
	cpuPkg::exMemT    exMem;
	cpuPkg::memWbT    memWb;
	cpuPkg::redirectT jumpRedirect;
	cpuPkg::redirectT branchRedirect;
	logic             stall;

	fetchStage fetchUnit (
		.clk            (clk),
		.rst            (rst),
		.imemLoad       (imemLoad),
		.stall          (stall),
		.jumpRedirect   (jumpRedirect),
		.branchRedirect (branchRedirect),
		.ifId           (ifId)
	);

	decodeStage decodeUnit (
		.clk            (clk),
		.rst            (rst),
		.ifId           (ifId),
		.memWb          (memWb),
		.branchRedirect (branchRedirect),
		.idEx           (idEx),
		.stall          (stall),
		.jumpRedirect   (jumpRedirect)
	);

	executeStage executeUnit (
		.clk            (clk),
		.rst            (rst),
		.idEx           (idEx),
		.memWb          (memWb),
		.exMem          (exMem),
		.branchRedirect (branchRedirect)
	);

	memoryStage memoryUnit (
		.clk   (clk),
		.rst   (rst),
		.exMem (exMem),
		.memWb (memWb),
		.store (store)
	);

	// Write-back record doubles as the retire port
	assign retire = memWb;

endmodule

// ==== logic/cpuPkg.sv ====
// Shared sizes, MIPS encodings and pipeline record types, referenced by scoped name from every stage
package cpuPkg;

	// *********************************************************
	// Sizes
	// *********************************************************
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int imemDepth = 64;
	localparam int dmemDepth = 64;
	localparam int imemAddrWidth = $clog2(imemDepth);
	localparam int dmemAddrWidth = $clog2(dmemDepth);

	// Opcode field, instr[31:26]
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// Funct field of R-type, instr[5:0]
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr  = 6'h25;
	localparam logic [5:0] functSlt = 6'h2a;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

	// *********************************************************
	// Control bundle and pipeline records
	// *********************************************************
	typedef struct packed {
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  branch;
		logic  aluSrcImm;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic                 valid;
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		logic                    valid;
		ctrlT                    ctrl;
		logic [dataWidth-1:0]    rsValue;
		logic [dataWidth-1:0]    rtValue;
		logic [dataWidth-1:0]    imm;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0]    branchTarget;
	} idExT;

	typedef struct packed {
		logic                    valid;
		logic                    regWrite;
		logic                    memRead;
		logic                    memWrite;
		logic [dataWidth-1:0]    aluResult;
		logic [dataWidth-1:0]    storeValue;
		logic [regAddrWidth-1:0] dest;
	} exMemT;

	// Also the retire record seen at the top level
	typedef struct packed {
		logic                    valid;
		logic                    regWrite;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0]    result;
	} memWbT;

	typedef struct packed {
		logic                 taken;
		logic [dataWidth-1:0] target;
	} redirectT;

	typedef struct packed {
		logic                 valid;
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] data;
	} storeT;

	typedef struct packed {
		logic                     writeEn;
		logic [imemAddrWidth-1:0] addr;
		logic [dataWidth-1:0]     instr;
	} imemLoadT;

endpackage

// ==== logic/decodeStage.sv ====
// Decode stage with control decode, register file, jump redirect, load-use stall and ID/EX register
module decodeStage (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::ifIdT     ifId,
	input  cpuPkg::memWbT    memWb,
	input  cpuPkg::redirectT branchRedirect,
	output cpuPkg::idExT     idEx,
	output logic             stall,
	output cpuPkg::redirectT jumpRedirect
);

	logic [cpuPkg::dataWidth-1:0]    regs [2**cpuPkg::regAddrWidth];
	logic [5:0]                      opcode;
	logic [5:0]                      funct;
	logic [cpuPkg::regAddrWidth-1:0] rs;
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::regAddrWidth-1:0] rd;
	logic [cpuPkg::regAddrWidth-1:0] dest;
	logic [cpuPkg::dataWidth-1:0]    imm;
	logic [cpuPkg::dataWidth-1:0]    rsValue;
	logic [cpuPkg::dataWidth-1:0]    rtValue;
	cpuPkg::ctrlT                    ctrl;
	logic                            isJump;
	logic                            usesRs;
	logic                            usesRt;
	logic                            wbWrite;

	assign opcode = ifId.instr[31:26];
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign funct = ifId.instr[5:0];
	assign imm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

	// Immediate forms write rt
	assign dest = (opcode == cpuPkg::opRtype) ? rd : rt;

	// *********************************************************
	// Main control
	// *********************************************************
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = cpuPkg::aluAdd;
		isJump = 1'b0;
		case (opcode)
			cpuPkg::opRtype: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					cpuPkg::functAdd: ctrl.aluOp = cpuPkg::aluAdd;
					cpuPkg::functSub: ctrl.aluOp = cpuPkg::aluSub;
					cpuPkg::functAnd: ctrl.aluOp = cpuPkg::aluAnd;
					cpuPkg::functOr:  ctrl.aluOp = cpuPkg::aluOr;
					cpuPkg::functSlt: ctrl.aluOp = cpuPkg::aluSlt;
					default:          ctrl.regWrite = 1'b0;
				endcase
			end
			cpuPkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			cpuPkg::opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			cpuPkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			cpuPkg::opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = cpuPkg::aluSub;
			end
			cpuPkg::opJ: isJump = 1'b1;
			// Anything else falls through as a no-op
			default: ;
		endcase
		// A write to register 0 is dropped here and never retires
		if (dest == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

	// *********************************************************
	// Register file with write-back bypass
	// *********************************************************
	assign wbWrite = memWb.valid && memWb.regWrite && (memWb.dest != '0);

	always_ff @(posedge clk) begin
		if (wbWrite) begin
			regs[memWb.dest] <= memWb.result;
		end
	end

	function automatic logic [cpuPkg::dataWidth-1:0] readReg(
		input logic [cpuPkg::regAddrWidth-1:0] idx
	);
		if (idx == '0) begin
			return '0;
		end else if (wbWrite && (memWb.dest == idx)) begin
			return memWb.result;
		end
		return regs[idx];
	endfunction

	always_comb begin
		rsValue = readReg(rs);
		rtValue = readReg(rt);
	end

	// Load in ID/EX feeding an operand of the instruction in IF/ID
	assign usesRs = ctrl.regWrite | ctrl.memWrite | ctrl.branch;
	assign usesRt = (ctrl.regWrite & ~ctrl.aluSrcImm) | ctrl.memWrite | ctrl.branch;
	assign stall = ifId.valid && idEx.valid && idEx.ctrl.memRead && (idEx.dest != '0)
		&& ((usesRs && (idEx.dest == rs)) || (usesRt && (idEx.dest == rt)));

	// Jump target keeps the upper PC region
	assign jumpRedirect.taken = ifId.valid && isJump;
	assign jumpRedirect.target = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			idEx.valid <= 1'b0;
		end else begin
			// Bubble on a stall or behind a taken branch
			idEx.valid <= ifId.valid && !stall && !branchRedirect.taken;
			idEx.ctrl <= ctrl;
			idEx.rsValue <= rsValue;
			idEx.rtValue <= rtValue;
			idEx.imm <= imm;
			idEx.rs <= rs;
			idEx.rt <= rt;
			idEx.dest <= dest;
			idEx.branchTarget <= ifId.pcPlus4 + {imm[29:0], 2'b00};
		end
	end

endmodule

// ==== logic/executeStage.sv ====
// Execute stage with operand forwarding, ALU, beq resolution and the EX/MEM register
module executeStage (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::idExT     idEx,
	input  cpuPkg::memWbT    memWb,
	output cpuPkg::exMemT    exMem,
	output cpuPkg::redirectT branchRedirect
);

	logic [cpuPkg::dataWidth-1:0] opA;
	logic [cpuPkg::dataWidth-1:0] opB;
	logic [cpuPkg::dataWidth-1:0] aluB;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic                         sltBit;

	// *********************************************************
	// Forwarding
	// *********************************************************

	// Youngest producer wins, register 0 is never forwarded
	function automatic logic [cpuPkg::dataWidth-1:0] forward(
		input logic [cpuPkg::regAddrWidth-1:0] idx,
		input logic [cpuPkg::dataWidth-1:0]    regValue
	);
		if (idx == '0) begin
			return regValue;
		end else if (exMem.valid && exMem.regWrite && (exMem.dest == idx)) begin
			return exMem.aluResult;
		end else if (memWb.valid && memWb.regWrite && (memWb.dest == idx)) begin
			return memWb.result;
		end
		return regValue;
	endfunction

	always_comb begin
		opA = forward(idEx.rs, idEx.rsValue);
		opB = forward(idEx.rt, idEx.rtValue);
	end

	assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

	// *********************************************************
	// ALU
	// *********************************************************
	assign sltBit = $signed(opA) < $signed(aluB);

	always_comb begin
		case (idEx.ctrl.aluOp)
			cpuPkg::aluAdd: aluResult = opA + aluB;
			cpuPkg::aluSub: aluResult = opA - aluB;
			cpuPkg::aluAnd: aluResult = opA & aluB;
			cpuPkg::aluOr:  aluResult = opA | aluB;
			cpuPkg::aluSlt: aluResult = {{(cpuPkg::dataWidth-1){1'b0}}, sltBit};
			default:        aluResult = opA + aluB;
		endcase
	end

	// Equality on the forwarded operands, squash happens upstream
	assign branchRedirect.taken = idEx.valid && idEx.ctrl.branch && (opA == opB);
	assign branchRedirect.target = idEx.branchTarget;

	// *********************************************************
	// EX/MEM register
	// *********************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			exMem.valid <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem.valid <= idEx.valid;
			// Effects only for a live entry
			exMem.regWrite <= idEx.valid && idEx.ctrl.regWrite;
			exMem.memRead <= idEx.valid && idEx.ctrl.memRead;
			exMem.memWrite <= idEx.valid && idEx.ctrl.memWrite;
			exMem.aluResult <= aluResult;
			exMem.storeValue <= opB;
			exMem.dest <= idEx.dest;
		end
	end

endmodule

// ==== logic/fetchStage.sv ====
// Fetch stage with PC, instruction memory loaded over imemLoad, next-PC choice and IF/ID register
module fetchStage (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::imemLoadT imemLoad,
	input  logic             stall,
	input  cpuPkg::redirectT jumpRedirect,
	input  cpuPkg::redirectT branchRedirect,
	output cpuPkg::ifIdT     ifId
);

	logic [cpuPkg::dataWidth-1:0] imem [cpuPkg::imemDepth];
	logic [cpuPkg::dataWidth-1:0] pc;
	logic [cpuPkg::dataWidth-1:0] pcPlus4;
	logic [cpuPkg::dataWidth-1:0] nextPc;
	logic [cpuPkg::dataWidth-1:0] instr;
	logic                         squash;

	// Program image written while the core sits in reset
	always_ff @(posedge clk) begin
		if (imemLoad.writeEn) begin
			imem[imemLoad.addr] <= imemLoad.instr;
		end
	end

	// Word addressed fetch
	assign instr = imem[pc[cpuPkg::imemAddrWidth+1:2]];
	assign pcPlus4 = pc + 32'd4;

	// Branch beats jump, either beats the stall hold
	always_comb begin
		if (branchRedirect.taken) begin
			nextPc = branchRedirect.target;
		end else if (jumpRedirect.taken) begin
			nextPc = jumpRedirect.target;
		end else if (stall) begin
			nextPc = pc;
		end else begin
			nextPc = pcPlus4;
		end
	end

	assign squash = branchRedirect.taken | jumpRedirect.taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			ifId.valid <= 1'b0;
		end else begin
			pc <= nextPc;
			if (squash) begin
				ifId.valid <= 1'b0;
			end else if (!stall) begin
				ifId.valid <= 1'b1;
				ifId.instr <= instr;
				ifId.pcPlus4 <= pcPlus4;
			end
		end
	end

endmodule

// ==== logic/memoryStage.sv ====
// Memory stage with word-addressed data memory, store reporting and the MEM/WB register
module memoryStage (
	input  logic          clk,
	input  logic          rst,
	input  cpuPkg::exMemT exMem,
	output cpuPkg::memWbT memWb,
	output cpuPkg::storeT store
);

	logic [cpuPkg::dataWidth-1:0]     dmem [cpuPkg::dmemDepth];
	logic [cpuPkg::dmemAddrWidth-1:0] wordAddr;
	logic [cpuPkg::dataWidth-1:0]     loadData;
	logic                             doStore;

	// Byte address in, low two bits dropped
	assign wordAddr = exMem.aluResult[cpuPkg::dmemAddrWidth+1:2];
	assign loadData = dmem[wordAddr];
	assign doStore = exMem.valid && exMem.memWrite;

	always_ff @(posedge clk) begin
		if (doStore) begin
			dmem[wordAddr] <= exMem.storeValue;
		end
	end

	// One-cycle strobe per executed sw
	assign store.valid = doStore;
	assign store.addr = exMem.aluResult;
	assign store.data = exMem.storeValue;

	always_ff @(posedge clk) begin
		if (rst) begin
			memWb.valid <= 1'b0;
			memWb.regWrite <= 1'b0;
		end else begin
			memWb.valid <= exMem.valid;
			memWb.regWrite <= exMem.regWrite;
			memWb.dest <= exMem.dest;
			memWb.result <= exMem.memRead ? loadData : exMem.aluResult;
		end
	end

endmodule

// ==== verification/cpuTb.sv ====
// Directed testbench for the pipelined core, predicts retire and store order with an ISA model
module cpuTb;
	timeunit 1ns;
	timeprecision 100ps;

	logic             clk;
	logic             rst;
	cpuPkg::imemLoadT imemLoad;
	cpuPkg::memWbT    retire;
	cpuPkg::storeT    store;

	// Program image and architectural state of the reference model
	logic [cpuPkg::dataWidth-1:0] prog [cpuPkg::imemDepth];
	logic [cpuPkg::dataWidth-1:0] mregs [32];
	logic [cpuPkg::dataWidth-1:0] mmem [cpuPkg::dmemDepth];
	int                           progLen;

	cpuPkg::memWbT expRetire [$];
	cpuPkg::memWbT gotRetire [$];
	cpuPkg::storeT expStore [$];
	cpuPkg::storeT gotStore [$];

	int seed = 32'h1598_411f;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	int cycleLimit = 50;

	cpu i_dut (
		.clk      (clk),
		.rst      (rst),
		.imemLoad (imemLoad),
		.retire   (retire),
		.store    (store)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// Outputs only move on the rising edge
	always @(negedge clk) begin
		if (retire.valid === 1'b1 && retire.regWrite === 1'b1) begin
			gotRetire.push_back(retire);
		end
		if (store.valid === 1'b1) begin
			gotStore.push_back(store);
		end
	end

	// Limit grows with each test as it starts
	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Run stopped after %0d cycles before all tests finished", cycleCount);
		$display("TEST FAIL");
		$finish;
	end

	// ************************************************************
	// Assembler helpers
	// ************************************************************
	function automatic logic [31:0] rFormat(input logic [5:0] funct, input int rd, input int rs,
		input int rt);
		return {cpuPkg::opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic logic [31:0] iFormat(input logic [5:0] op, input int rt, input int rs,
		input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [31:0] jFormat(input int wordAddr);
		return {cpuPkg::opJ, 26'(wordAddr)};
	endfunction

	function automatic int randImm();
		logic [31:0] r;
		r = $random(seed);
		return int'($signed(r[15:0]));
	endfunction

	// Unused words hold an undefined opcode tagged with their address
	function automatic void newProgram();
		int i;
		for (i = 0; i < cpuPkg::imemDepth; i++) begin
			prog[i] = 32'hfc00_0000 | 32'(i);
		end
		progLen = 0;
	endfunction

	function automatic void append(input logic [31:0] word);
		prog[progLen] = word;
		progLen++;
	endfunction

	// ************************************************************
	// Reference model
	// ************************************************************

	// Writes to register 0 are dropped and never retire
	function automatic void noteWrite(input logic [4:0] dest, input logic [31:0] value);
		cpuPkg::memWbT rec;
		if (dest != 5'd0) begin
			rec.valid = 1'b1;
			rec.regWrite = 1'b1;
			rec.dest = dest;
			rec.result = value;
			expRetire.push_back(rec);
			mregs[dest] = value;
		end
	endfunction

	// Runs the program in order until it reaches a jump to itself
	task automatic predict();
		logic [31:0]   pc;
		logic [31:0]   nextPc;
		logic [31:0]   ins;
		logic [31:0]   a;
		logic [31:0]   b;
		logic [31:0]   imm;
		logic [31:0]   addr;
		cpuPkg::storeT st;
		int            steps;
		logic          parked;
		pc = '0;
		steps = 0;
		parked = 1'b0;
		expRetire.delete();
		expStore.delete();
		while (!parked && steps < 4 * cpuPkg::imemDepth) begin
			ins = prog[pc[cpuPkg::imemAddrWidth+1:2]];
			a = mregs[ins[25:21]];
			b = mregs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			nextPc = pc + 32'd4;
			addr = a + imm;
			case (ins[31:26])
				cpuPkg::opRtype: begin
					case (ins[5:0])
						cpuPkg::functAdd: noteWrite(ins[15:11], a + b);
						cpuPkg::functSub: noteWrite(ins[15:11], a - b);
						cpuPkg::functAnd: noteWrite(ins[15:11], a & b);
						cpuPkg::functOr:  noteWrite(ins[15:11], a | b);
						cpuPkg::functSlt: noteWrite(ins[15:11],
							($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: ;
					endcase
				end
				cpuPkg::opAddi: noteWrite(ins[20:16], a + imm);
				cpuPkg::opLw: noteWrite(ins[20:16], mmem[addr[cpuPkg::dmemAddrWidth+1:2]]);
				cpuPkg::opSw: begin
					mmem[addr[cpuPkg::dmemAddrWidth+1:2]] = b;
					st.valid = 1'b1;
					st.addr = addr;
					st.data = b;
					expStore.push_back(st);
				end
				cpuPkg::opBeq: begin
					if (a == b) begin
						nextPc = nextPc + {imm[29:0], 2'b00};
					end
				end
				cpuPkg::opJ: begin
					nextPc = {nextPc[31:28], ins[25:0], 2'b00};
					parked = (nextPc == pc);
				end
				default: ;
			endcase
			pc = nextPc;
			steps++;
		end
	endtask

	// ************************************************************
	// Compare tasks
	// ************************************************************
	task automatic checkRetire(input cpuPkg::memWbT expected, input cpuPkg::memWbT actual);
		if (actual !== expected) begin
			$display("error at %0t ns: retire expected r%0d = %h, actual r%0d = %h", $time,
				expected.dest, expected.result, actual.dest, actual.result);
			errorCount++;
		end
	endtask

	task automatic checkStore(input cpuPkg::storeT expected, input cpuPkg::storeT actual);
		if (actual !== expected) begin
			$display("error at %0t ns: store expected [%h] = %h, actual [%h] = %h", $time,
				expected.addr, expected.data, actual.addr, actual.data);
			errorCount++;
		end
	endtask

	// ************************************************************
	// Test sequencing
	// ************************************************************
	task automatic loadProgram();
		int i;
		rst = 1'b1;
		for (i = 0; i < cpuPkg::imemDepth; i++) begin
			imemLoad.writeEn = 1'b1;
			imemLoad.addr = i[cpuPkg::imemAddrWidth-1:0];
			imemLoad.instr = prog[i];
			@(negedge clk);
		end
		imemLoad = '0;
		repeat (2) @(negedge clk);
		gotRetire.delete();
		gotStore.delete();
		rst = 1'b0;
	endtask

	task automatic runProgram(input string name);
		int budget;
		int waited;
		int errorsBefore;
		int i;
		// Self jump parks the core when the program is done
		append(jFormat(progLen));
		predict();
		budget = 10 * progLen;
		cycleLimit += budget + cpuPkg::imemDepth + 40;
		loadProgram();
		waited = 0;
		while ((gotRetire.size() < expRetire.size() || gotStore.size() < expStore.size())
			&& waited < budget) begin
			@(posedge clk);
			waited++;
		end
		// Room for late extra events
		repeat (10) @(negedge clk);
		errorsBefore = errorCount;
		if (gotRetire.size() != expRetire.size()) begin
			$display("%s: DUT retired %0d register writes where %0d were expected", name,
				gotRetire.size(), expRetire.size());
			errorCount++;
		end
		for (i = 0; i < gotRetire.size() && i < expRetire.size(); i++) begin
			checkRetire(expRetire[i], gotRetire[i]);
		end
		if (gotStore.size() != expStore.size()) begin
			$display("%s: DUT made %0d stores where %0d were expected", name,
				gotStore.size(), expStore.size());
			errorCount++;
		end
		for (i = 0; i < gotStore.size() && i < expStore.size(); i++) begin
			checkStore(expStore[i], gotStore[i]);
		end
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("%s: passed", name);
		end else begin
			failCount++;
			$display("%s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// ************************************************************
	// Directed tests
	// ************************************************************
	task automatic arithmeticChain();
		newProgram();
		append(iFormat(cpuPkg::opAddi, 1, 0, randImm()));
		append(iFormat(cpuPkg::opAddi, 2, 1, randImm()));
		// r1 comes from MEM/WB, r2 from EX/MEM
		append(rFormat(cpuPkg::functAdd, 3, 1, 2));
		append(rFormat(cpuPkg::functSub, 4, 3, 1));
		append(rFormat(cpuPkg::functAnd, 5, 4, 3));
		append(rFormat(cpuPkg::functOr, 6, 5, 2));
		append(rFormat(cpuPkg::functSlt, 7, 6, 4));
		append(rFormat(cpuPkg::functSlt, 8, 4, 6));
		append(rFormat(cpuPkg::functAdd, 9, 7, 8));
		runProgram("arithmetic forwarding");
	endtask

	task automatic storeAndLoad();
		newProgram();
		append(iFormat(cpuPkg::opAddi, 1, 0, randImm()));
		append(iFormat(cpuPkg::opAddi, 2, 0, randImm()));
		append(iFormat(cpuPkg::opSw, 1, 0, 8));
		append(iFormat(cpuPkg::opSw, 2, 0, 12));
		append(iFormat(cpuPkg::opAddi, 10, 0, 16));
		append(iFormat(cpuPkg::opSw, 2, 10, 4));
		append(iFormat(cpuPkg::opLw, 3, 0, 8));
		// Load-use on an ALU operand
		append(rFormat(cpuPkg::functAdd, 4, 3, 2));
		append(iFormat(cpuPkg::opLw, 5, 0, 20));
		// Load-use on store data
		append(iFormat(cpuPkg::opSw, 5, 0, 24));
		append(iFormat(cpuPkg::opLw, 6, 0, 12));
		append(rFormat(cpuPkg::functAdd, 7, 0, 6));
		append(iFormat(cpuPkg::opSw, 7, 10, 28));
		runProgram("stores and loads");
	endtask

	task automatic branchPaths();
		newProgram();
		append(iFormat(cpuPkg::opAddi, 1, 0, 5));
		append(iFormat(cpuPkg::opAddi, 2, 0, 5));
		append(iFormat(cpuPkg::opBeq, 2, 1, 2));
		append(iFormat(cpuPkg::opAddi, 3, 0, 1));
		append(iFormat(cpuPkg::opAddi, 4, 0, 2));
		append(iFormat(cpuPkg::opAddi, 5, 0, 3));
		// Not taken, 5 against 3
		append(iFormat(cpuPkg::opBeq, 5, 1, 1));
		append(iFormat(cpuPkg::opAddi, 6, 0, 4));
		runProgram("beq taken and not taken");
	endtask

	task automatic jumpShadow();
		newProgram();
		append(iFormat(cpuPkg::opAddi, 1, 0, 7));
		append(jFormat(4));
		append(iFormat(cpuPkg::opAddi, 1, 0, 99));
		append(iFormat(cpuPkg::opAddi, 2, 0, 99));
		append(iFormat(cpuPkg::opAddi, 2, 1, 1));
		runProgram("jump over shadow");
	endtask

	task automatic zeroRegister();
		newProgram();
		// Writes to $0 never retire, reads of $0 stay zero
		append(iFormat(cpuPkg::opAddi, 0, 0, randImm()));
		append(rFormat(cpuPkg::functAdd, 11, 0, 0));
		append(iFormat(cpuPkg::opAddi, 0, 11, 5));
		append(rFormat(cpuPkg::functOr, 12, 0, 0));
		append(iFormat(cpuPkg::opAddi, 13, 0, 1));
		runProgram("register zero");
	endtask

	task automatic undefinedOpcodes();
		newProgram();
		append(iFormat(cpuPkg::opAddi, 1, 0, 3));
		append(iFormat(6'h0d, 1, 1, 65535));
		append(rFormat(6'h3f, 1, 1, 1));
		append(iFormat(6'h28, 1, 0, 32));
		append(iFormat(6'h3f, 1, 1, 1));
		append(iFormat(cpuPkg::opAddi, 2, 1, 4));
		runProgram("undefined opcodes");
	endtask

	initial begin
		int r;
		rst = 1'b1;
		imemLoad = '0;
		for (r = 0; r < 32; r++) begin
			mregs[r] = '0;
		end
		@(negedge clk);
		arithmeticChain();
		storeAndLoad();
		branchPaths();
		jumpShadow();
		zeroRegister();
		undefinedOpcodes();
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== verification/cpu_assertions.sv ====
// Concurrent checks on pipeline control and write-back, bound into every decodeStage instance
module cpu_assertions (
	input logic             clk,
	input logic             rst,
	input logic             stall,
	input cpuPkg::idExT     idEx,
	input cpuPkg::memWbT    memWb,
	input cpuPkg::redirectT branchRedirect
);
	timeunit 1ns;
	timeprecision 100ps;

	// Pipeline registers are empty right after reset
	noStallAfterReset: assert property (@(posedge clk) rst |=> !stall)
		else $error("load-use stall raised in the first cycle after reset");

	// Taken branch leaves a bubble in ID/EX
	branchSquashesIdEx: assert property (
		@(posedge clk) disable iff (rst) branchRedirect.taken |=> !idEx.valid
	) else $error("valid ID/EX entry behind a taken branch");

	// Register 0 never shows up as a written retire
	noZeroRegRetire: assert property (
		@(posedge clk) disable iff (rst) (memWb.valid && memWb.regWrite) |-> (memWb.dest != '0)
	) else $error("retire with regWrite set targets register 0");

endmodule

bind decodeStage cpu_assertions pipelineChecks (
	.clk            (clk),
	.rst            (rst),
	.stall          (stall),
	.idEx           (idEx),
	.memWb          (memWb),
	.branchRedirect (branchRedirect)
);
